//--- sdram_pkg.sv
// SDRAM geometry, timing constants, command encoding and controller states
`default_nettype none

package sdram_pkg;

    localparam int sdram_aw = 22;                 // Word address width, one word is 16 bits
    localparam int sdram_dw = 16;                 // Data bus width
    localparam int col_w    = 9;                  // Column bits at the bottom of the word address
    localparam int row_w    = sdram_aw - col_w;   // Row bits above the column
    localparam int mem_aw   = 13;                 // Address pins, as wide as a row

    localparam int cas_latency      = 2;  // Edges from the read command to the first word
    localparam int trfc             = 4;  // Cycles the device stays busy after auto-refresh
    localparam int refresh_interval = 64; // Default spacing of auto-refresh commands

    // Encoded as {ras_n, cas_n, we_n}, with chip select held low
    typedef enum logic [2:0] {
        cmd_nop       = 3'b111,
        cmd_active    = 3'b011,
        cmd_read      = 3'b101,
        cmd_precharge = 3'b010,
        cmd_refresh   = 3'b001
    } sdram_cmd_e;

    typedef enum logic [2:0] {
        st_idle,      // Waiting for a request or a pending refresh
        st_activate,  // Row opened, the read goes out next
        st_read,      // Read command is on the pins
        st_wait_data, // Counting CAS latency and collecting both words
        st_precharge, // Row is being closed
        st_refresh    // Auto-refresh recovery time
    } sdram_state_e;

endpackage

`default_nettype wire

//--- rom_pkg.sv
// Slot-side constants, cache line type and request FSM states
`default_nettype none

package rom_pkg;

    localparam int line_bytes      = 4;   // Bytes in one cache line, that is two SDRAM words
    localparam int slot_dw_default = 16;  // Slot width used when the top level sets none

    // Line data with the lowest byte address in the low bits
    typedef logic [8*line_bytes-1:0] line_t;

    // The request side waits for the ack, then for each word of the burst
    typedef enum logic [1:0] {
        rq_idle,       // Serving hits, a miss raises the request
        rq_wait_ack,   // Request level is up until the slot owns the bus
        rq_wait_first, // Waiting for the low word of the line
        rq_wait_last   // Waiting for the high word of the line
    } req_state_e;

endpackage

`default_nettype wire

//--- rom_request.sv
// Single-line ROM cache: hit test, output multiplexer, burst assembly and request strobe
`timescale 1ns/100ps
`default_nettype none

module rom_request
    import sdram_pkg::*, rom_pkg::*;
#(
    parameter int SLOT_DW = slot_dw_default,  // 8, 16 or 32
    parameter int SLOT_AW = 20                // Address width in slot-width units
)(
    input  wire                 clk,
    input  wire                 rst,
    input  wire [SLOT_AW-1:0]   addr,
    input  wire                 addr_ok,     // Chip select level from the client
    output logic [SLOT_DW-1:0]  dout,
    output logic                data_ok,
    output logic                req,         // Level, held until the ack is seen through we
    output logic [sdram_aw-1:0] sdram_addr,  // Line-aligned word address
    input  wire                 we,          // Bus ownership, high from ack to rdy
    input  wire [sdram_dw-1:0]  din,
    input  wire                 dst,         // First word on din
    input  wire                 din_ok       // Second word on din
);

    // Number of address bits that pick a slot word inside the line
    localparam int sel_w = $clog2(line_bytes * 8 / SLOT_DW);

    req_state_e         state;
    line_t              line_data;   // Cached bytes
    logic [SLOT_AW-1:0] line_tag;    // Line address of the cached bytes
    logic               line_valid;
    logic [SLOT_AW-1:0] req_tag;     // Line address of the burst in flight
    logic [SLOT_AW-1:0] line_addr;   // Line address of what the client asks for now
    logic               hit;
    logic               miss_start;  // A new request goes out on this edge
    logic               take_first;
    logic               take_last;
    logic [SLOT_DW-1:0] dout_next;

    assign line_addr  = addr >> sel_w;  // Upper bits fill with zeros
    assign hit        = line_valid && line_tag == line_addr;
    assign miss_start = state == rq_idle && addr_ok && !hit;
    assign take_first = state == rq_wait_first && we && dst;
    assign take_last  = state == rq_wait_last && we && din_ok;

    // Low address bits choose the byte or half word, a 32-bit slot takes the whole line
    generate
        if (SLOT_DW == 8) begin : g_byte
            assign dout_next = line_data[{addr[1:0], 3'b000} +: 8];
        end else if (SLOT_DW == 16) begin : g_half
            assign dout_next = line_data[{addr[0], 4'b0000} +: 16];
        end else begin : g_word
            assign dout_next = line_data;
        end
    endgenerate

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            data_ok <= 1'b0;
        end else begin
            data_ok <= addr_ok && hit; // A new line or a dropped cs clears ok on the next edge
        end
    end

    // Data follows addr every cycle so it always lines up with data_ok
    always_ff @(posedge clk) begin
        dout <= dout_next;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= rq_idle;
            req        <= 1'b0;
            line_valid <= 1'b0;
        end else begin
            case (state)
                rq_idle: begin
                    if (miss_start) begin
                        req   <= 1'b1;
                        state <= rq_wait_ack;
                    end
                end
                rq_wait_ack: begin
                    if (we) begin         // Controller took the request one cycle ago
                        req   <= 1'b0;
                        state <= rq_wait_first;
                    end
                end
                rq_wait_first: begin
                    if (take_first) begin
                        line_valid <= 1'b0; // Half-filled line must not hit
                        state      <= rq_wait_last;
                    end
                end
                rq_wait_last: begin
                    if (take_last) begin
                        line_valid <= 1'b1;
                        state      <= rq_idle;
                    end
                end
                default: state <= rq_idle;
            endcase
        end
    end

    // Tag and address of the burst, then both words of the line
    always_ff @(posedge clk) begin
        if (miss_start) begin
            req_tag    <= line_addr;
            sdram_addr <= sdram_aw'({line_addr, 1'b0}); // Two words per line
        end
        if (take_first) begin
            line_data[sdram_dw-1:0] <= din;            // Low word holds bytes 0 and 1
        end
        if (take_last) begin
            line_data[2*sdram_dw-1:sdram_dw] <= din;
            line_tag <= req_tag;     // Tag the line with the address that was fetched
        end
    end

    // A burst only starts after this block raised a request
    a_dst_not_idle: assert property (@(posedge clk) disable iff (rst)
        dst |-> state != rq_idle)
        else $error("rom_request: dst seen while idle");

endmodule

`default_nettype wire

//--- rom_one_slot.sv
// Single ROM slot: data-bus ownership flag around the request and cache block
`timescale 1ns/100ps
`default_nettype none

module rom_one_slot
    import sdram_pkg::*, rom_pkg::*;
#(
    parameter int SLOT_DW = slot_dw_default,
    parameter int SLOT_AW = 20
)(
    input  wire                 clk,
    input  wire                 rst,
    input  wire [SLOT_AW-1:0]   slot_addr,
    input  wire                 slot_cs,
    output logic [SLOT_DW-1:0]  slot_dout,
    output logic                slot_ok,
    input  wire                 sdram_ack,
    output logic                sdram_req,
    output logic [sdram_aw-1:0] sdram_addr,
    input  wire                 data_dst,
    input  wire                 data_rdy,
    input  wire [sdram_dw-1:0]  data_read
);

    logic owner; // The burst on data_read belongs to this slot

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            owner <= 1'b0;
        end else if (sdram_ack) begin
            owner <= 1'b1;   // Taken when the controller accepts the request
        end else if (data_rdy) begin
            owner <= 1'b0;   // Released after the last word
        end
    end

    rom_request #(
        .SLOT_DW (SLOT_DW),
        .SLOT_AW (SLOT_AW)
    ) u_request (
        .clk        (clk),
        .rst        (rst),
        .addr       (slot_addr),
        .addr_ok    (slot_cs),
        .dout       (slot_dout),
        .data_ok    (slot_ok),
        .req        (sdram_req),
        .sdram_addr (sdram_addr),
        .we         (owner),
        .din        (data_read),
        .dst        (data_dst),
        .din_ok     (data_rdy)
    );

    // One burst in flight, so the controller cannot accept again before rdy
    a_ack_not_owned: assert property (@(posedge clk) disable iff (rst)
        sdram_ack |-> !owner)
        else $error("rom_one_slot: ack while the bus is still owned");

endmodule

`default_nettype wire

//--- sdram_read_ctrl.sv
// SDRAM read sequencer: activate, read, CAS wait, precharge and periodic auto-refresh
`timescale 1ns/100ps
`default_nettype none

module sdram_read_ctrl
    import sdram_pkg::*;
#(
    parameter int REFRESH_CYCLES = refresh_interval
)(
    input  wire                 clk,
    input  wire                 rst,
    input  wire                 req,      // Level from the slot
    input  wire [sdram_aw-1:0]  addr,     // Word address, row above column
    output logic                ack,      // One-cycle pulse together with the activate
    output logic                dst,      // First word valid on dout
    output logic                rdy,      // Second word valid on dout
    output logic [sdram_dw-1:0] dout,
    output sdram_cmd_e          mem_cmd,
    output logic [mem_aw-1:0]   mem_addr,
    input  wire [sdram_dw-1:0]  mem_dq
);

    localparam int ref_w = $clog2(REFRESH_CYCLES);

    sdram_state_e     state;
    logic [ref_w-1:0] ref_cnt;   // Cycles since the last refresh slot
    logic             ref_pend;  // A refresh is due
    logic             ref_take;  // The pending refresh goes out on this edge
    logic [2:0]       cnt;       // Edges since the read or the refresh command
    logic [col_w-1:0] col;       // Column held from activate until read

    assign ref_take = state == st_idle && ref_pend;

    // Refresh timer, the request only waits while a refresh is pending
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ref_cnt  <= '0;
            ref_pend <= 1'b0;
        end else if (ref_cnt == ref_w'(REFRESH_CYCLES - 1)) begin
            ref_cnt  <= '0;
            ref_pend <= 1'b1;    // A new interval elapsed, even if one was just taken
        end else begin
            ref_cnt <= ref_cnt + ref_w'(1);
            if (ref_take) begin
                ref_pend <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= st_idle;
            mem_cmd <= cmd_nop;
            ack     <= 1'b0;
            dst     <= 1'b0;
            rdy     <= 1'b0;
            cnt     <= '0;
        end else begin
            mem_cmd <= cmd_nop;  // Commands and strobes last a single cycle
            ack     <= 1'b0;
            dst     <= 1'b0;
            rdy     <= 1'b0;
            case (state)
                st_idle: begin
                    if (ref_pend) begin
                        mem_cmd <= cmd_refresh;
                        cnt     <= '0;
                        state   <= st_refresh;
                    end else if (req) begin
                        ack     <= 1'b1;
                        mem_cmd <= cmd_active;
                        state   <= st_activate;
                    end
                end
                st_activate: begin
                    mem_cmd <= cmd_read;   // Row is open after one cycle in this model
                    state   <= st_read;
                end
                st_read: begin
                    cnt   <= 3'd1;         // This edge samples the read command
                    state <= st_wait_data;
                end
                st_wait_data: begin
                    cnt <= cnt + 3'd1;
                    if (cnt == 3'(cas_latency)) begin
                        dst <= 1'b1;       // First word sampled now
                    end
                    if (cnt == 3'(cas_latency + 1)) begin
                        rdy     <= 1'b1;   // Second word sampled now
                        mem_cmd <= cmd_precharge;
                        state   <= st_precharge;
                    end
                end
                st_precharge: state <= st_idle;
                st_refresh: begin
                    cnt <= cnt + 3'd1;
                    if (cnt == 3'(trfc - 1)) begin
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // Address pins, read data and the latched column
    always_ff @(posedge clk) begin
        case (state)
            st_idle:     mem_addr <= addr[sdram_aw-1 -: row_w]; // Row for the activate
            st_activate: mem_addr <= mem_aw'(col);  // A10 stays low, so no auto precharge
            default:     mem_addr <= '0;
        endcase
        if (state == st_idle) begin
            col <= addr[col_w-1:0];
        end
        if (state == st_wait_data) begin
            dout <= mem_dq;    // Valid on the cycles where dst or rdy is high
        end
    end

    // The row must be open before any column read
    a_read_after_act: assert property (@(posedge clk) disable iff (rst)
        mem_cmd == cmd_read |-> $past(mem_cmd) == cmd_active)
        else $error("sdram_read_ctrl: read without a preceding activate");

endmodule

`default_nettype wire

//--- rom_subsystem.sv
// Top level of the ROM port: one cached slot joined to the SDRAM read controller
`timescale 1ns/100ps
`default_nettype none

module rom_subsystem
    import sdram_pkg::*, rom_pkg::*;
#(
    parameter int SLOT_DW        = slot_dw_default,
    parameter int SLOT_AW        = 20,
    parameter int REFRESH_CYCLES = refresh_interval
)(
    input  wire                 clk,
    input  wire                 rst,
    input  wire [SLOT_AW-1:0]   slot_addr,
    input  wire                 slot_cs,
    output logic [SLOT_DW-1:0]  slot_dout,
    output logic                slot_ok,
    output sdram_cmd_e          mem_cmd,
    output logic [mem_aw-1:0]   mem_addr,
    input  wire [sdram_dw-1:0]  mem_dq
);

    logic                sdram_req;   // Slot wants a line
    logic                sdram_ack;   // Controller took it
    logic [sdram_aw-1:0] sdram_addr;
    logic                data_dst;
    logic                data_rdy;
    logic [sdram_dw-1:0] data_read;   // Burst words as seen by the slot

    rom_one_slot #(
        .SLOT_DW (SLOT_DW),
        .SLOT_AW (SLOT_AW)
    ) u_slot (
        .clk        (clk),
        .rst        (rst),
        .slot_addr  (slot_addr),
        .slot_cs    (slot_cs),
        .slot_dout  (slot_dout),
        .slot_ok    (slot_ok),
        .sdram_ack  (sdram_ack),
        .sdram_req  (sdram_req),
        .sdram_addr (sdram_addr),
        .data_dst   (data_dst),
        .data_rdy   (data_rdy),
        .data_read  (data_read)
    );

    sdram_read_ctrl #(
        .REFRESH_CYCLES (REFRESH_CYCLES)
    ) u_ctrl (
        .clk      (clk),
        .rst      (rst),
        .req      (sdram_req),
        .addr     (sdram_addr),
        .ack      (sdram_ack),
        .dst      (data_dst),
        .rdy      (data_rdy),
        .dout     (data_read),
        .mem_cmd  (mem_cmd),
        .mem_addr (mem_addr),
        .mem_dq   (mem_dq)
    );

endmodule

`default_nettype wire

//--- tb_checker.sv
// Testbench checker: compares slot data with the expected value and counts SDRAM commands
`timescale 1ns/100ps
`default_nettype none

module tb_checker
    import sdram_pkg::*;
(
    input  wire        clk,
    input  wire        rst,
    input  wire        slot_ok,
    input  wire [15:0] slot_dout,
    input  wire [15:0] exp_dout,      // Expected data for the address presented now
    input  wire [2:0]  mem_cmd,
    input  wire [7:0]  test_id,       // Test in progress, used in error lines
    output int         err_count,
    output int         read_count,    // Read commands seen on the pins
    output int         refresh_count  // Auto-refresh commands seen on the pins
);

    logic [15:0] exp_q;  // Expectation for the address the DUT registered on the last edge

    // Readable name of each test for the error lines
    function automatic string name_of(input logic [7:0] id);
        case (id)
            8'd0:    return "reset";
            8'd1:    return "sequential_miss";
            8'd2:    return "repeated_hit";
            8'd3:    return "random_reads";
            8'd4:    return "refresh";
            8'd5:    return "address_change";
            default: return "unknown";
        endcase
    endfunction

    // Outputs of the DUT still hold their pre-edge values here
    always @(posedge clk or posedge rst) begin
        if (rst) begin
            err_count     <= 0;
            read_count    <= 0;
            refresh_count <= 0;
            exp_q         <= '0;
        end else begin
            exp_q <= exp_dout;
            if (slot_ok && slot_dout !== exp_q) begin
                $display("Error test %s: expected %h actual %h",
                         name_of(test_id), exp_q, slot_dout);
                err_count <= err_count + 1;
            end
            if (mem_cmd == cmd_read) begin
                read_count <= read_count + 1;
            end
            if (mem_cmd == cmd_refresh) begin
                refresh_count <= refresh_count + 1; // Spacing is judged by the testbench
            end
        end
    end

endmodule

`default_nettype wire

//--- tb_rom_subsystem.sv
// Testbench top: clock, reset, SDRAM model, reference function and test sequence
`timescale 1ns/100ps
`default_nettype none

module tb_rom_subsystem
    import sdram_pkg::*;
;

    localparam int slot_aw    = 20;
    localparam int ref_cycles = 64;
    localparam int wait_limit = 50;  // Worst miss with a refresh in front is far below this

    logic        clk;
    logic        rst;
    logic [19:0] slot_addr;
    logic        slot_cs;
    logic [15:0] slot_dout;
    logic        slot_ok;
    sdram_cmd_e  mem_cmd;
    logic [12:0] mem_addr;
    logic [15:0] mem_dq = '0;
    logic [15:0] exp_dout;
    logic [7:0]  test_id;
    int          err_count, read_count, refresh_count;
    int          cycle = 0;         // Clock edges since the start
    int          pass_cnt, fail_cnt;
    int          timeouts;          // Timeouts within the running test
    logic [12:0] open_row = '0;     // Row of the last activate
    logic [21:0] burst_addr = '0;   // Word address of the burst being returned
    int          read_age = 0;      // Edges since the read command, zero when none

    // Word value stored at an SDRAM word address
    function automatic logic [15:0] word_value(input logic [21:0] waddr);
        logic [31:0] p;
        p = waddr[15:0] * 32'd40503;
        return p[15:0] ^ 16'd23130;
    endfunction

    // With a 16-bit slot the slot address is the word address
    function automatic logic [15:0] expected_dout(input logic [19:0] a);
        return word_value({2'b00, a});
    endfunction

    assign exp_dout = expected_dout(slot_addr);

    rom_subsystem #(.SLOT_DW(16), .SLOT_AW(slot_aw), .REFRESH_CYCLES(ref_cycles)) DUT (
        .clk(clk), .rst(rst), .slot_addr(slot_addr), .slot_cs(slot_cs),
        .slot_dout(slot_dout), .slot_ok(slot_ok),
        .mem_cmd(mem_cmd), .mem_addr(mem_addr), .mem_dq(mem_dq)
    );

    tb_checker chk (
        .clk(clk), .rst(rst), .slot_ok(slot_ok), .slot_dout(slot_dout), .exp_dout(exp_dout),
        .mem_cmd(mem_cmd), .test_id(test_id), .err_count(err_count),
        .read_count(read_count), .refresh_count(refresh_count)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) cycle <= cycle + 1;

    // SDRAM model latches the row, then the column, and counts CAS latency
    always @(posedge clk) begin
        if (mem_cmd == cmd_active) open_row <= mem_addr;
        if (mem_cmd == cmd_read) begin
            burst_addr <= {open_row, mem_addr[col_w-1:0]};
            read_age   <= 1;
        end else if (read_age > 0) begin
            read_age <= (read_age > cas_latency) ? 0 : read_age + 1;
        end
    end

    // Words change on the falling edge so the controller samples stable data
    always @(negedge clk) begin
        if (read_age == cas_latency) mem_dq <= word_value(burst_addr);
        else if (read_age == cas_latency + 1) mem_dq <= word_value(burst_addr + 22'd1);
        else mem_dq <= 16'hxxxx;
    end

    // Presents one address and waits for slot_ok, returns the cycles it took
    task automatic read_addr(input logic [19:0] a, output int cycles);
        @(negedge clk);
        slot_addr = a;
        slot_cs   = 1'b1;
        @(negedge clk);
        cycles = 1;
        while (!slot_ok && cycles < wait_limit) begin
            @(negedge clk);
            cycles++;
        end
        if (!slot_ok) begin
            $display("Timeout: no slot_ok for address %h after %0d cycles", a, cycles);
            timeouts++;
        end
    endtask

    // One result line per test
    task automatic finish_test(input string name, input int errs_before, input logic extra_fail);
        if (err_count == errs_before && timeouts == 0 && !extra_fail) begin
            $display("Test %s passed", name);
            pass_cnt++;
        end else begin
            $display("Test %s failed", name);
            fail_cnt++;
        end
        timeouts = 0;
    endtask

    initial begin
        int e0, cyc, rc0, c0, r0;
        logic bad;
        void'($urandom(54901));
        pass_cnt  = 0;
        fail_cnt  = 0;
        timeouts  = 0;
        rst       = 1'b1;
        slot_addr = '0;
        slot_cs   = 1'b0;
        test_id   = 8'd0;
        repeat (8) @(posedge clk);
        @(negedge clk) rst = 1'b0;
        bad = mem_cmd != cmd_nop || slot_ok;  // Idle outputs straight out of reset
        if (bad) $display("Outputs are not idle after reset");
        finish_test("reset", 0, bad);

        test_id = 8'd1;
        e0      = err_count;
        for (int i = 0; i < 16; i++) read_addr(20'h00100 + 20'(2 * i), cyc);
        finish_test("sequential_miss", e0, 1'b0);

        test_id = 8'd2;
        e0      = err_count;
        read_addr(20'h02000, cyc);
        rc0 = read_count;
        read_addr(20'h02001, cyc);  // Other word of the same line
        bad = cyc != 1 || read_count != rc0;
        if (cyc != 1) begin
            $display("Error test repeated_hit: expected 1 cycle actual %0d", cyc);
        end
        if (read_count != rc0) begin
            $display("Error test repeated_hit: expected %0d reads actual %0d",
                     rc0, read_count);
        end
        finish_test("repeated_hit", e0, bad);

        test_id = 8'd3;
        e0      = err_count;
        for (int i = 0; i < 200; i++) read_addr(20'($urandom), cyc);
        finish_test("random_reads", e0, 1'b0);

        test_id = 8'd4;
        e0      = err_count;
        c0      = cycle;
        r0      = refresh_count;
        for (int i = 0; i < 300; i++) read_addr(20'($urandom) & 20'h000ff, cyc);
        bad = (refresh_count - r0) < (cycle - c0) / ref_cycles - 1;
        if (bad) begin
            $display("Error test refresh: expected at least %0d refreshes actual %0d",
                     (cycle - c0) / ref_cycles - 1, refresh_count - r0);
        end
        finish_test("refresh", e0, bad);

        test_id = 8'd5;
        e0      = err_count;
        bad     = 1'b0;
        for (int d = 1; d < 7; d++) begin
            @(negedge clk);
            slot_addr = 20'h40000 + 20'(d * 64);  // Miss that gets abandoned
            repeat (d) begin
                @(negedge clk);
                if (slot_ok) bad = 1'b1;
            end
            read_addr(20'h50000 + 20'(d * 64 + 1), cyc);
        end
        if (bad) $display("slot_ok rose before a miss could have completed");
        finish_test("address_change", e0, bad);

        $display("Tests passed %0d, failed %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- compile.f
sdram_pkg.sv
rom_pkg.sv
rom_request.sv
rom_one_slot.sv
sdram_read_ctrl.sv
rom_subsystem.sv
tb_checker.sv
tb_rom_subsystem.sv

//--- Makefile
TOP = tb_rom_subsystem

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f compile.f --top-module $(TOP) -o sim_$(TOP)

run: compile
	@out=$$(./obj_dir/sim_$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "Regression passed"

clean:
	rm -rf obj_dir
